// File: Makefile
# Verilator simulation of the execute stage

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_execStage -f execStage.f
	./obj_dir/Vtb_execStage > sim.log 2>&1
	cat sim.log
	if grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: execAlu.sv
`default_nettype none

`include "execStage_defines.svh"

module execAlu (
    input logic   clk,
    input logic   rst,
    execAluIf.alu alu
);

    localparam int halfW = `EXEC_DATA_W / 2;
    localparam int msb   = `EXEC_DATA_W - 1;

    logic [`EXEC_DATA_W:0] addSum;    // Carry in the top bit
    logic [`EXEC_DATA_W:0] subDiff;   // Borrow in the top bit
    execPkg::word_t        result;
    execPkg::flags_t       flagsQ;
    execPkg::flags_t       flagsNext;
    logic                  carry;
    logic                  overflow;
    logic                  zero;

    assign addSum  = {1'b0, alu.opA} + {1'b0, alu.opB};
    assign subDiff = {1'b0, alu.opA} - {1'b0, alu.opB};

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (alu.aluOp)
            execPkg::ADD: begin
                result   = addSum[msb:0];
                carry    = addSum[`EXEC_DATA_W];
                overflow = !(alu.opA[msb] ^ alu.opB[msb]) && (alu.opA[msb] ^ result[msb]);
            end
            execPkg::SUB: begin
                result   = subDiff[msb:0];
                carry    = !subDiff[`EXEC_DATA_W];   // C set when no borrow
                overflow = (alu.opA[msb] ^ alu.opB[msb]) && (alu.opA[msb] ^ result[msb]);
            end
            execPkg::AND:   result = alu.opA & alu.opB;
            execPkg::OR:    result = alu.opA | alu.opB;
            execPkg::XOR:   result = alu.opA ^ alu.opB;
            execPkg::NOT:   result = ~alu.opA;
            execPkg::LSL:   result = alu.opA << alu.opB;
            execPkg::LSR:   result = alu.opA >> alu.opB;
            execPkg::PASSB: result = alu.opB;
            execPkg::MOVT:  result = {alu.opB[halfW-1:0], alu.opA[halfW-1:0]};
            default:        result = '0;
        endcase
    end

    assign zero = (result == '0);

    always_comb begin
        flagsNext = flagsQ;
        case (alu.flagMode)
            execPkg::NZ: begin
                flagsNext[3] = result[msb];
                flagsNext[2] = zero;       // C and V kept
            end
            execPkg::NZCV: flagsNext = {result[msb], zero, carry, overflow};
            default: ;
        endcase
    end

    // NZCV register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flagsQ <= '0;
        end else if (alu.commit) begin
            flagsQ <= flagsNext;
        end
    end

    assign alu.result = result;
    assign alu.flags  = flagsQ;

    // Flags move only on an accepted instruction
    property flagsHoldP;
        @(posedge clk) disable iff (rst)
            !alu.commit |=> $stable(alu.flags);
    endproperty

    flagsHoldA: assert property (flagsHoldP)
        else $error("flags changed without commit");

endmodule

`default_nettype wire

// File: execAluIf.sv
`default_nettype none

// Operands and control from the decoder, result and flags back
interface execAluIf;

    execPkg::word_t     opA;
    execPkg::word_t     opB;
    execPkg::aluOp_t    aluOp;
    execPkg::flagMode_t flagMode;
    logic               commit;     // Instruction accepted this cycle
    execPkg::word_t     result;
    execPkg::flags_t    flags;

    modport decoder (
        output opA, opB, aluOp, flagMode, commit,
        input  result, flags
    );

    modport alu (
        input  opA, opB, aluOp, flagMode, commit,
        output result, flags
    );

endinterface

`default_nettype wire

// File: execApbMaster.sv
`default_nettype none

module execApbMaster (
    input  logic           clk,
    input  logic           rst,
    execMemIf.bus          mem,
    output logic           pSel,
    output logic           pEnable,
    output logic           pWrite,
    output execPkg::word_t pAddr,
    output execPkg::word_t pWdata,
    input  execPkg::word_t pRdata,
    input  logic           pReady
);

    execPkg::apbState_t state;
    execPkg::apbState_t stateNext;
    execPkg::word_t     addrQ;
    execPkg::word_t     wdataQ;
    logic               writeQ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= execPkg::IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            execPkg::IDLE:   if (mem.req) stateNext = execPkg::SETUP;
            execPkg::SETUP:  stateNext = execPkg::ACCESS;
            execPkg::ACCESS: if (pReady) stateNext = execPkg::IDLE;   // Wait states
            default:         stateNext = execPkg::IDLE;
        endcase
    end

    // Captured on the way into SETUP, held through ACCESS
    always_ff @(posedge clk) begin
        if (state == execPkg::IDLE && mem.req) begin
            addrQ  <= mem.addr;
            writeQ <= mem.write;
            wdataQ <= mem.wdata;
        end
    end

    assign pSel    = (state != execPkg::IDLE);
    assign pEnable = (state == execPkg::ACCESS);
    assign pWrite  = writeQ;
    assign pAddr   = addrQ;
    assign pWdata  = wdataQ;

    assign mem.done  = pEnable && pReady;
    assign mem.rdata = pRdata;

    // Access phase is always entered from a selected setup phase
    property enableAfterSelP;
        @(posedge clk) disable iff (rst)
            pEnable |-> pSel && $past(pSel);
    endproperty

    enableAfterSelA: assert property (enableAfterSelP)
        else $error("pEnable without preceding pSel");

    property addrStableP;
        @(posedge clk) disable iff (rst)
            pSel && !(pEnable && pReady) |=>
                $stable(pAddr) && $stable(pWrite) && $stable(pWdata);
    endproperty

    addrStableA: assert property (addrStableP)
        else $error("APB address or data changed mid transfer");

endmodule

`default_nettype wire

// File: execDecode.sv
`default_nettype none

`include "execStage_defines.svh"

module execDecode (
    input  logic               instValid,
    output logic               instReady,
    input  execPkg::opClass_t  firstLevelDecode,
    input  logic               specialEncoding,
    input  logic [3:0]         secondLevelDecode,
    input  logic [2:0]         aluFunctions,
    input  logic [3:0]         branchInstruction,
    input  execPkg::imm_t      imm,
    input  execPkg::regIdx_t   destReg,
    input  execPkg::regIdx_t   sourceFirstReg,
    input  execPkg::regIdx_t   sourceSecReg,
    input  execPkg::word_t     readDataDest,
    input  execPkg::word_t     readDataFirst,
    input  execPkg::word_t     readDataSec,
    output execPkg::regIdx_t   readRegDest,
    output execPkg::regIdx_t   readRegFirst,
    output execPkg::regIdx_t   readRegSec,
    output execPkg::word_t     writeData,
    output logic               writeToReg,
    output logic               branchTaken,
    execAluIf.decoder          alu,
    execMemIf.decoder          mem
);

    localparam logic [3:0] BEQ = 4'b0000;
    localparam logic [3:0] BNE = 4'b0001;
    localparam logic [3:0] BMI = 4'b0100;

    execPkg::word_t     immSext;
    execPkg::word_t     immZext;
    execPkg::aluOp_t    arithOp;
    execPkg::flagMode_t arithFlags;
    logic               arithValid;
    logic               immArithOk;   // Immediate group has no NOT
    logic               aluWrite;
    logic               memOp;
    logic               loadOp;
    logic               branchCond;

    assign immSext = {{(`EXEC_DATA_W-`EXEC_IMM_W){imm[`EXEC_IMM_W-1]}}, imm};
    assign immZext = {{(`EXEC_DATA_W-`EXEC_IMM_W){1'b0}}, imm};

    // Shared by the register and immediate arithmetic groups
    always_comb begin
        arithValid = 1'b1;
        arithOp    = execPkg::ADD;
        case (secondLevelDecode[2:0])
            3'b001:  arithOp = execPkg::ADD;
            3'b010:  arithOp = execPkg::SUB;
            3'b011:  arithOp = execPkg::AND;
            3'b100:  arithOp = execPkg::OR;
            3'b101:  arithOp = execPkg::XOR;
            3'b110:  arithOp = execPkg::NOT;
            default: arithValid = 1'b0;
        endcase
        if (!arithValid || !secondLevelDecode[3])
            arithFlags = execPkg::KEEP;
        else if (arithOp == execPkg::ADD || arithOp == execPkg::SUB)
            arithFlags = execPkg::NZCV;   // Only sums touch C and V
        else
            arithFlags = execPkg::NZ;
    end

    assign immArithOk = arithValid && (arithOp != execPkg::NOT);

    always_comb begin
        readRegDest  = '0;
        readRegFirst = '0;
        readRegSec   = '0;
        alu.opA      = readDataFirst;
        alu.opB      = immSext;
        alu.aluOp    = execPkg::ADD;
        alu.flagMode = execPkg::KEEP;
        aluWrite     = 1'b0;
        memOp        = 1'b0;
        branchCond   = 1'b0;
        case (firstLevelDecode)
            execPkg::MOVIMM: begin
                readRegDest = destReg;
                if (specialEncoding) begin
                    readRegFirst = sourceFirstReg;
                    alu.aluOp    = arithOp;
                    alu.flagMode = immArithOk ? arithFlags : execPkg::KEEP;
                    aluWrite     = immArithOk;
                end else begin
                    alu.opB   = immZext;
                    alu.aluOp = execPkg::PASSB;
                    aluWrite  = 1'b1;
                    case (aluFunctions)
                        3'b000: alu.aluOp = execPkg::PASSB;   // MOV
                        3'b001: begin
                            alu.opA   = readDataDest;
                            alu.aluOp = execPkg::MOVT;
                        end
                        3'b010: alu.opB = '0;                 // CLR
                        3'b011: alu.opB = '1;                 // SET
                        3'b100: begin
                            readRegFirst = sourceFirstReg;
                            alu.aluOp    = execPkg::LSL;
                        end
                        3'b101: begin
                            readRegFirst = sourceFirstReg;
                            alu.aluOp    = execPkg::LSR;
                        end
                        3'b110: alu.opB = {{(`EXEC_DATA_W-`EXEC_FLAG_W){1'b0}}, alu.flags};
                        default: aluWrite = 1'b0;
                    endcase
                end
            end
            execPkg::REGOP: begin
                readRegDest  = destReg;
                readRegFirst = sourceFirstReg;
                readRegSec   = (arithOp == execPkg::NOT) ? '0 : sourceSecReg;
                alu.opB      = readDataSec;
                alu.aluOp    = arithOp;
                alu.flagMode = arithFlags;
                aluWrite     = arithValid;
            end
            execPkg::MEMOP: begin
                readRegDest  = destReg;          // Store data or load target
                readRegFirst = sourceFirstReg;   // Base address
                memOp        = 1'b1;
            end
            execPkg::BRANCH: begin
                case (branchInstruction)
                    BEQ:     branchCond = alu.flags[2];
                    BNE:     branchCond = !alu.flags[2];
                    BMI:     branchCond = alu.flags[3];
                    default: branchCond = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign loadOp    = memOp && !aluFunctions[0];
    assign mem.req   = instValid && memOp;
    assign mem.write = aluFunctions[0];
    assign mem.addr  = alu.result;     // Base plus sign extended offset
    assign mem.wdata = readDataDest;

    assign instReady   = !mem.req || mem.done;
    assign alu.commit  = instValid && instReady;
    assign writeToReg  = instValid && (aluWrite || (loadOp && mem.done));
    assign writeData   = loadOp ? mem.rdata : alu.result;
    assign branchTaken = instValid && branchCond;

endmodule

`default_nettype wire

// File: execMemIf.sv
`default_nettype none

// Load/store request from the decoder to the bus master
interface execMemIf;

    logic           req;      // Held until done
    logic           write;
    execPkg::word_t addr;
    execPkg::word_t wdata;
    logic           done;     // Single cycle pulse
    execPkg::word_t rdata;

    modport decoder (
        output req, write, addr, wdata,
        input  done, rdata
    );

    modport bus (
        input  req, write, addr, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

// File: execPkg.sv
`default_nettype none

`include "execStage_defines.svh"

package execPkg;

    typedef logic [`EXEC_DATA_W-1:0]       word_t;
    typedef logic signed [`EXEC_IMM_W-1:0] imm_t;
    typedef logic [`EXEC_REG_W-1:0]        regIdx_t;
    typedef logic [`EXEC_FLAG_W-1:0]       flags_t;   // N Z C V, N at the top

    // Top two opcode bits
    typedef enum logic [1:0] {
        MOVIMM = 2'b00,
        REGOP  = 2'b01,
        MEMOP  = 2'b10,
        BRANCH = 2'b11
    } opClass_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        NOT,
        LSL,
        LSR,
        PASSB,   // Result is opB
        MOVT     // Low half of opB over low half of opA
    } aluOp_t;

    // Which flags a committed operation updates
    typedef enum logic [1:0] {
        KEEP,
        NZ,
        NZCV
    } flagMode_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apbState_t;

endpackage

`default_nettype wire

// File: execStage.f
+incdir+.
execPkg.sv
execAluIf.sv
execMemIf.sv
execDecode.sv
execAlu.sv
execApbMaster.sv
execStage.sv
tb_execStage.sv

// File: execStage.sv
`default_nettype none

module execStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              instValid,
    output logic              instReady,
    input  execPkg::opClass_t firstLevelDecode,
    input  logic              specialEncoding,
    input  logic [3:0]        secondLevelDecode,
    input  logic [2:0]        aluFunctions,
    input  logic [3:0]        branchInstruction,
    input  execPkg::imm_t     imm,
    input  execPkg::regIdx_t  destReg,
    input  execPkg::regIdx_t  sourceFirstReg,
    input  execPkg::regIdx_t  sourceSecReg,
    input  execPkg::word_t    readDataDest,
    input  execPkg::word_t    readDataFirst,
    input  execPkg::word_t    readDataSec,
    output execPkg::regIdx_t  readRegDest,
    output execPkg::regIdx_t  readRegFirst,
    output execPkg::regIdx_t  readRegSec,
    output execPkg::word_t    writeData,
    output logic              writeToReg,
    output logic              branchTaken,
    output logic              pSel,        // APB master
    output logic              pEnable,
    output logic              pWrite,
    output execPkg::word_t    pAddr,
    output execPkg::word_t    pWdata,
    input  execPkg::word_t    pRdata,
    input  logic              pReady
);

    execAluIf aluBus ();
    execMemIf memBus ();

    execDecode i_decode (
        .instValid         (instValid),
        .instReady         (instReady),
        .firstLevelDecode  (firstLevelDecode),
        .specialEncoding   (specialEncoding),
        .secondLevelDecode (secondLevelDecode),
        .aluFunctions      (aluFunctions),
        .branchInstruction (branchInstruction),
        .imm               (imm),
        .destReg           (destReg),
        .sourceFirstReg    (sourceFirstReg),
        .sourceSecReg      (sourceSecReg),
        .readDataDest      (readDataDest),
        .readDataFirst     (readDataFirst),
        .readDataSec       (readDataSec),
        .readRegDest       (readRegDest),
        .readRegFirst      (readRegFirst),
        .readRegSec        (readRegSec),
        .writeData         (writeData),
        .writeToReg        (writeToReg),
        .branchTaken       (branchTaken),
        .alu               (aluBus.decoder),
        .mem               (memBus.decoder)
    );

    // Datapath and NZCV
    execAlu i_alu (
        .clk (clk),
        .rst (rst),
        .alu (aluBus.alu)
    );

    execApbMaster i_apb (
        .clk     (clk),
        .rst     (rst),
        .mem     (memBus.bus),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWdata  (pWdata),
        .pRdata  (pRdata),
        .pReady  (pReady)
    );

endmodule

`default_nettype wire

// File: execStage_defines.svh
`ifndef EXEC_STAGE_DEFINES_SVH
`define EXEC_STAGE_DEFINES_SVH

// Datapath word width
`define EXEC_DATA_W 32

// Immediate field of the instruction, sign bit at the top
`define EXEC_IMM_W 16

// Register file has 16 entries
`define EXEC_REG_W 4

// N, Z, C, V
`define EXEC_FLAG_W 4

`endif

// File: tb_execStage.sv
`default_nettype none

module tb_execStage;

    logic              clk = 1'b0;
    logic              rst;
    logic              instValid;
    logic              instReady;
    execPkg::opClass_t firstLevelDecode;
    logic              specialEncoding;
    logic [3:0]        secondLevelDecode;
    logic [2:0]        aluFunctions;
    logic [3:0]        branchInstruction;
    execPkg::imm_t     imm;
    execPkg::regIdx_t  destReg;
    execPkg::regIdx_t  sourceFirstReg;
    execPkg::regIdx_t  sourceSecReg;
    execPkg::word_t    readDataDest;
    execPkg::word_t    readDataFirst;
    execPkg::word_t    readDataSec;
    execPkg::regIdx_t  readRegDest;
    execPkg::regIdx_t  readRegFirst;
    execPkg::regIdx_t  readRegSec;
    execPkg::word_t    writeData;
    logic              writeToReg;
    logic              branchTaken;
    logic              pSel;
    logic              pEnable;
    logic              pWrite;
    execPkg::word_t    pAddr;
    execPkg::word_t    pWdata;
    execPkg::word_t    pRdata = '0;
    logic              pReady = 1'b0;

    execPkg::word_t    regFile [16];   // External register file
    execPkg::flags_t   modelFlags;     // Reference NZCV
    execPkg::word_t    expData;
    execPkg::word_t    expAddr;
    execPkg::word_t    expWdata;
    execPkg::regIdx_t  expDest;
    execPkg::regIdx_t  expFirst;
    execPkg::regIdx_t  expSec;
    logic              expBranch;
    logic              idleCheck;
    logic              checkWrite;
    logic              checkBranch;
    logic              checkStore;
    logic              checkLoad;
    logic              checkMem;
    logic              accepted = 1'b0;
    int                seed = 75;
    int                waitLeft = 0;
    int                errCount;
    int                testCount;
    int                passCount;

    assign readDataDest  = regFile[readRegDest];   // Same cycle read
    assign readDataFirst = regFile[readRegFirst];
    assign readDataSec   = regFile[readRegSec];

    execStage i_execStage (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    // APB slave with 0 to 3 wait states per transfer
    always @(negedge clk) begin
        if (pSel && !pEnable) begin
            waitLeft = $random(seed) & 3;
            pRdata   = $random(seed);
            pReady   = 1'b0;
        end else if (pSel && pEnable) begin
            pReady = (waitLeft == 0);
            if (waitLeft != 0)
                waitLeft = waitLeft - 1;
        end else begin
            pReady = 1'b0;
        end
    end

    always @(posedge clk) begin
        accepted <= instValid && instReady;
    end

    idleA: assert property (@(posedge clk) disable iff (rst)
        idleCheck |-> !pSel && !pEnable && !writeToReg && !branchTaken && instReady)
        else begin
            errCount = errCount + 1;
            $display("** Error idle pSel %h pEnable %h writeToReg %h branchTaken %h instReady %h",
                     $sampled(pSel), $sampled(pEnable), $sampled(writeToReg),
                     $sampled(branchTaken), $sampled(instReady));
        end

    writeA: assert property (@(posedge clk) disable iff (rst)
        checkWrite |-> writeToReg && instReady && writeData == expData)
        else begin
            errCount = errCount + 1;
            $display("** Error writeData got %h expected %h, writeToReg %h",
                     $sampled(writeData), expData, $sampled(writeToReg));
        end

    selA: assert property (@(posedge clk) disable iff (rst)
        checkWrite |-> readRegDest == expDest && readRegFirst == expFirst && readRegSec == expSec)
        else begin
            errCount = errCount + 1;
            $display("** Error readRegDest %h expected %h readRegFirst %h expected %h %s %h %s %h",
                     $sampled(readRegDest), expDest, $sampled(readRegFirst), expFirst,
                     "readRegSec", $sampled(readRegSec), "expected", expSec);
        end

    branchA: assert property (@(posedge clk) disable iff (rst)
        checkBranch |-> branchTaken == expBranch && !writeToReg)
        else begin
            errCount = errCount + 1;
            $display("** Error branchTaken got %h expected %h writeToReg %h",
                     $sampled(branchTaken), expBranch, $sampled(writeToReg));
        end

    storeA: assert property (@(posedge clk) disable iff (rst)
        checkStore && pEnable && pReady |-> pWrite && pAddr == expAddr && pWdata == expWdata)
        else begin
            errCount = errCount + 1;
            $display("** Error store pWrite %h pAddr %h expected %h pWdata %h expected %h",
                     $sampled(pWrite), $sampled(pAddr), expAddr, $sampled(pWdata), expWdata);
        end

    loadA: assert property (@(posedge clk) disable iff (rst)
        checkLoad && pEnable && pReady |-> !pWrite && writeToReg && writeData == pRdata)
        else begin
            errCount = errCount + 1;
            $display("** Error load writeData %h expected %h writeToReg %h pWrite %h",
                     $sampled(writeData), $sampled(pRdata), $sampled(writeToReg),
                     $sampled(pWrite));
        end

    // Slave model raises pReady only in the completing access cycle
    readyA: assert property (@(posedge clk) disable iff (rst)
        checkMem |-> instReady == pReady)
        else begin
            errCount = errCount + 1;
            $display("** Error instReady got %h expected %h",
                     $sampled(instReady), $sampled(pReady));
        end

    setupA: assert property (@(posedge clk) disable iff (rst)
        pSel && !pEnable |=> pSel && pEnable)
        else begin
            errCount = errCount + 1;
            $display("APB setup phase was not followed by an access phase");
        end

    holdA: assert property (@(posedge clk) disable iff (rst)
        pSel && pEnable && !pReady |=> pSel && pEnable)
        else begin
            errCount = errCount + 1;
            $display("APB access phase ended before pReady");
        end

    endA: assert property (@(posedge clk) disable iff (rst)
        pSel && pEnable && pReady |=> !pSel)
        else begin
            errCount = errCount + 1;
            $display("APB bus stayed selected after a completed transfer");
        end

    // Reference ALU that also updates modelFlags when S is set
    function automatic execPkg::word_t predict(input logic [2:0] code, input logic sBit,
                                               input execPkg::word_t a, input execPkg::word_t b);
        logic [32:0]    wide;
        execPkg::word_t r;
        wide = '0;
        case (code)
            3'd1:    wide = {1'b0, a} + {1'b0, b};
            3'd2:    wide = {1'b0, a} + {1'b0, ~b} + 33'd1;   // Carry out means no borrow
            3'd3:    wide[31:0] = a & b;
            3'd4:    wide[31:0] = a | b;
            3'd5:    wide[31:0] = a ^ b;
            default: wide[31:0] = ~a;
        endcase
        r = wide[31:0];
        if (sBit) begin
            modelFlags[3] = r[31];
            modelFlags[2] = (r == '0);
            if (code == 3'd1 || code == 3'd2) begin
                modelFlags[1] = wide[32];
                if (code == 3'd1)
                    modelFlags[0] = (a[31] == b[31]) && (r[31] != a[31]);
                else
                    modelFlags[0] = (a[31] != b[31]) && (r[31] != a[31]);
            end
        end
        return r;
    endfunction

    task automatic startInst(input logic [1:0] cls, input logic spec, input logic [3:0] sld,
                             input logic [2:0] fn, input logic [3:0] br,
                             input logic [15:0] immV);
        @(negedge clk);
        firstLevelDecode  = execPkg::opClass_t'(cls);
        specialEncoding   = spec;
        secondLevelDecode = sld;
        aluFunctions      = fn;
        branchInstruction = br;
        imm               = immV;
        destReg           = 4'($random(seed));
        sourceFirstReg    = 4'($random(seed));
        sourceSecReg      = sourceFirstReg ^ 4'(($random(seed) & 7) + 1);   // Never equal
        instValid         = 1'b1;
    endtask

    // Holds the instruction until the DUT accepts it
    task automatic endInst();
        int n;
        bit done;
        done = 1'b0;
        for (n = 0; n < 20 && !done; n++) begin
            @(negedge clk);
            done = accepted;
        end
        if (!done) begin
            errCount = errCount + 1;
            $display("instruction was not accepted within 20 cycles");
        end else if (checkWrite) begin
            regFile[destReg] = expData;
        end
        instValid   = 1'b0;
        checkWrite  = 1'b0;
        checkBranch = 1'b0;
        checkStore  = 1'b0;
        checkLoad   = 1'b0;
        checkMem    = 1'b0;
    endtask

    task automatic regOp(input logic [2:0] code, input logic sBit,
                         input execPkg::word_t a, input execPkg::word_t b);
        startInst(2'b01, 1'b0, {sBit, code}, 3'b000, 4'b0000, 16'h0000);
        regFile[sourceFirstReg] = a;
        regFile[sourceSecReg]   = b;
        expData    = predict(code, sBit, a, b);
        expDest    = destReg;
        expFirst   = sourceFirstReg;
        expSec     = (code == 3'd6) ? 4'd0 : sourceSecReg;   // NOT reads one source
        checkWrite = 1'b1;
        endInst();
    endtask

    task automatic immOp(input logic [2:0] code, input logic sBit, input logic [15:0] immV);
        startInst(2'b00, 1'b1, {sBit, code}, 3'b000, 4'b0000, immV);
        expData    = predict(code, sBit, regFile[sourceFirstReg], {{16{immV[15]}}, immV});
        expDest    = destReg;
        expFirst   = sourceFirstReg;
        expSec     = 4'd0;
        checkWrite = 1'b1;
        endInst();
    endtask

    task automatic movOp(input logic [2:0] fn, input logic [15:0] immV);
        execPkg::word_t a;
        startInst(2'b00, 1'b0, 4'b0000, fn, 4'b0000, immV);
        a        = regFile[sourceFirstReg];
        expDest  = destReg;
        expFirst = (fn == 3'b100 || fn == 3'b101) ? sourceFirstReg : 4'd0;
        expSec   = 4'd0;
        case (fn)
            3'b000:  expData = {16'h0000, immV};
            3'b001:  expData = {immV, regFile[destReg][15:0]};
            3'b010:  expData = 32'h0000_0000;
            3'b011:  expData = 32'hFFFF_FFFF;
            3'b100:  expData = a << immV;
            3'b101:  expData = a >> immV;
            default: expData = {28'h000_0000, modelFlags};   // MOVF
        endcase
        checkWrite = 1'b1;
        endInst();
    endtask

    task automatic branchOp(input logic [3:0] br);
        startInst(2'b11, 1'b0, 4'b0000, 3'b000, br, 16'h0000);
        case (br)
            4'b0000: expBranch = modelFlags[2];
            4'b0001: expBranch = !modelFlags[2];
            4'b0100: expBranch = modelFlags[3];
            default: expBranch = 1'b0;
        endcase
        checkBranch = 1'b1;
        endInst();
    endtask

    task automatic memOp(input logic isStore, input logic [15:0] immV);
        startInst(2'b10, 1'b0, 4'b0000, {2'b00, isStore}, 4'b0000, immV);
        expAddr    = regFile[sourceFirstReg] + {{16{immV[15]}}, immV};
        expWdata   = regFile[destReg];
        checkStore = isStore;
        checkLoad  = !isStore;
        checkMem   = 1'b1;
        endInst();
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount = testCount + 1;
        if (errCount == errBefore) begin
            passCount = passCount + 1;
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name, errCount - errBefore);
        end
    endtask

    initial begin
        int e;
        rst               = 1'b1;
        instValid         = 1'b0;
        firstLevelDecode  = execPkg::MOVIMM;
        specialEncoding   = 1'b0;
        secondLevelDecode = 4'b0000;
        aluFunctions      = 3'b000;
        branchInstruction = 4'b0000;
        imm               = '0;
        destReg           = '0;
        sourceFirstReg    = '0;
        sourceSecReg      = '0;
        modelFlags        = '0;
        {idleCheck, checkWrite, checkBranch, checkStore, checkLoad, checkMem} = '0;
        errCount          = 0;
        testCount         = 0;
        passCount         = 0;
        for (int r = 0; r < 16; r++)
            regFile[r] = $random(seed);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e = errCount;
        idleCheck = 1'b1;
        repeat (3) @(negedge clk);
        idleCheck = 1'b0;
        reportTest("reset state", e);

        e = errCount;
        for (int i = 0; i < 12; i++) begin
            regOp(3'(1 + i / 2), 1'(i % 2), $random(seed), $random(seed));
            movOp(3'b110, 16'h0000);
        end
        regOp(3'd1, 1'b1, 32'hFFFF_FFFF, 32'h0000_0001);   // Z and C
        movOp(3'b110, 16'h0000);
        regOp(3'd1, 1'b1, 32'h7FFF_FFFF, 32'h0000_0001);   // N and V
        movOp(3'b110, 16'h0000);
        regOp(3'd2, 1'b1, 32'h8000_0000, 32'h0000_0001);
        movOp(3'b110, 16'h0000);
        regOp(3'd2, 1'b1, 32'h0000_0001, 32'h0000_0002);   // Borrow clears C
        movOp(3'b110, 16'h0000);
        regOp(3'd1, 1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        regOp(3'd5, 1'b1, 32'h1234_5678, 32'h1234_5678);   // NZ only so C is kept
        movOp(3'b110, 16'h0000);
        reportTest("register ALU and flags", e);

        e = errCount;
        for (int i = 0; i < 10; i++)
            immOp(3'(1 + i % 5), 1'(i / 5), 16'($random(seed)));
        immOp(3'd1, 1'b0, 16'h8000);
        immOp(3'd2, 1'b1, 16'hFFFF);
        for (int f = 0; f < 4; f++)
            movOp(3'(f), 16'($random(seed)));
        movOp(3'b100, 16'($random(seed) & 31));
        movOp(3'b101, 16'($random(seed) & 31));
        reportTest("immediate and move", e);

        e = errCount;
        regOp(3'd1, 1'b1, 32'h0000_0000, 32'h0000_0000);
        branchOp(4'b0000);
        branchOp(4'b0001);
        branchOp(4'b0100);
        branchOp(4'b0010);
        regOp(3'd2, 1'b1, 32'h0000_0001, 32'h0000_0002);
        branchOp(4'b0000);
        branchOp(4'b0001);
        branchOp(4'b0100);
        branchOp(4'b1111);
        reportTest("branches", e);

        e = errCount;
        repeat (4) memOp(1'b1, 16'($random(seed)));
        reportTest("stores", e);

        e = errCount;
        repeat (8) memOp(1'b0, 16'($random(seed)));
        reportTest("loads", e);

        $display("summary: %0d of %0d tests ok, %0d errors", passCount, testCount, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        for (int c = 0; c < 5000; c++)
            @(posedge clk);
        $display("simulation did not finish within 5000 cycles");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
